// File: wh_dma_macros.svh
`ifndef WH_DMA_MACROS_SVH
`define WH_DMA_MACROS_SVH

// link field widths
`define WH_FLIT_WIDTH 32
`define WH_CORD_WIDTH 8
`define WH_CID_WIDTH 2
`define WH_LEN_WIDTH 4

// cache side
`define NUM_SLOTS 4
`define BLOCK_WORDS 4
`define DMA_ADDR_WIDTH 28

// test memory and buffering
`define DRAM_WORDS 64
`define IN_FIFO_ELS 4

`endif

// File: wh_dma_pkg.sv
`include "wh_dma_macros.svh"

package wh_dma_pkg;

  // one direction of a wormhole link
  typedef struct packed {
    logic                      v;
    logic [`WH_FLIT_WIDTH-1:0] data;
  } wh_link_s;

  // first flit of every packet, in both directions
  typedef struct packed {
    logic [`WH_FLIT_WIDTH-2-2*`WH_CORD_WIDTH-`WH_CID_WIDTH-`WH_LEN_WIDTH:0] unused;
    logic                      write_not_read;
    logic [`WH_CORD_WIDTH-1:0] src_cord;
    logic [`WH_CID_WIDTH-1:0]  cid;
    logic [`WH_LEN_WIDTH-1:0]  len;
    logic [`WH_CORD_WIDTH-1:0] dest_cord;
  } wh_header_flit_s;

  // request handed to one cache DMA port
  typedef struct packed {
    logic                       write_not_read;
    logic [`DMA_ADDR_WIDTH-1:0] addr;
  } dma_pkt_s;

  // what the return path needs to address the reply
  typedef struct packed {
    logic [`WH_CID_WIDTH-1:0]  cid;
    logic [`WH_CORD_WIDTH-1:0] src_cord;
  } wh_route_s;

  typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_id_t;

endpackage

// File: wh_flit_fifo.sv
`timescale 1ns/1ps

module wh_flit_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  els_p     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int count_width_lp = $clog2(els_p + 1);

  payload_t                  mem_r [els_p];
  logic [ptr_width_lp-1:0]   wptr_r;
  logic [ptr_width_lp-1:0]   rptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      push;

  // wrap at els_p, which need not be a power of two
  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] p);
    return (p == ptr_width_lp'(els_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ready_o = (count_r != count_width_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign push    = v_i & ready_o;
  assign data_o  = mem_r[rptr_r];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (yumi_i) begin
        rptr_r <= next_ptr(rptr_r);
      end
      case ({push, yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // consumer may only take what is there
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

// File: wh_dma_send.sv
`timescale 1ns/1ps
`include "wh_dma_macros.svh"

module wh_dma_send (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       fifo_v_i,
  input  logic [`WH_FLIT_WIDTH-1:0]  fifo_data_i,
  output logic                       fifo_yumi_o,
  output wh_dma_pkg::dma_pkt_s       dma_pkt_o,
  output logic [`NUM_SLOTS-1:0]      dma_pkt_v_o,
  input  logic [`NUM_SLOTS-1:0]      dma_pkt_yumi_i,
  output logic [`WH_FLIT_WIDTH-1:0]  evict_data_o,
  output logic [`NUM_SLOTS-1:0]      evict_v_o,
  input  logic [`NUM_SLOTS-1:0]      evict_yumi_i,
  input  wh_dma_pkg::slot_id_t       route_slot_i,
  output wh_dma_pkg::wh_route_s      route_o
);

  import wh_dma_pkg::*;

  localparam int count_width_lp = $clog2(`BLOCK_WORDS);

  typedef enum logic [1:0] {
    SEND_RESET,
    SEND_READY,
    SEND_PKT,
    SEND_EVICT
  } send_state_e;

  send_state_e               state_r;
  send_state_e               state_n;
  slot_id_t                  slot_r;
  slot_id_t                  slot_n;
  slot_id_t                  hdr_slot;
  logic                      wnr_r;
  logic                      wnr_n;
  logic [count_width_lp-1:0] count_r;
  logic [count_width_lp-1:0] count_n;
  logic                      table_we;
  wh_header_flit_s           hdr;
  wh_route_s                 route_table_r [`NUM_SLOTS];

  // slot comes straight from the low bits of the source x
  assign hdr      = wh_header_flit_s'(fifo_data_i);
  assign hdr_slot = hdr.src_cord[$bits(slot_id_t)-1:0];

  // address flit sits at the head of the FIFO while in SEND_PKT
  assign dma_pkt_o.write_not_read = wnr_r;
  assign dma_pkt_o.addr           = fifo_data_i[`DMA_ADDR_WIDTH-1:0];
  assign evict_data_o             = fifo_data_i;

  assign route_o = route_table_r[route_slot_i];

  always_comb begin
    state_n     = state_r;
    slot_n      = slot_r;
    wnr_n       = wnr_r;
    count_n     = count_r;
    table_we    = 1'b0;
    fifo_yumi_o = 1'b0;
    dma_pkt_v_o = '0;
    evict_v_o   = '0;
    case (state_r)
      SEND_RESET: begin
        state_n = SEND_READY;
      end
      // header is consumed here and its route recorded
      SEND_READY: begin
        if (fifo_v_i) begin
          fifo_yumi_o = 1'b1;
          table_we    = 1'b1;
          slot_n      = hdr_slot;
          wnr_n       = hdr.write_not_read;
          state_n     = SEND_PKT;
        end
      end
      SEND_PKT: begin
        dma_pkt_v_o[slot_r] = fifo_v_i;
        if (dma_pkt_yumi_i[slot_r]) begin
          fifo_yumi_o = 1'b1;
          count_n     = '0;
          state_n     = wnr_r ? SEND_EVICT : SEND_READY;
        end
      end
      SEND_EVICT: begin
        evict_v_o[slot_r] = fifo_v_i;
        if (evict_yumi_i[slot_r]) begin
          fifo_yumi_o = 1'b1;
          if (count_r == count_width_lp'(`BLOCK_WORDS - 1)) begin
            count_n = '0;
            state_n = SEND_READY;
          end else begin
            count_n = count_r + 1'b1;
          end
        end
      end
      default: begin
        state_n = SEND_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (table_we) begin
      route_table_r[hdr_slot] <= '{cid: hdr.cid, src_cord: hdr.src_cord};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= SEND_RESET;
      slot_r  <= '0;
      wnr_r   <= 1'b0;
      count_r <= '0;
    end else begin
      state_r <= state_n;
      slot_r  <= slot_n;
      wnr_r   <= wnr_n;
      count_r <= count_n;
    end
  end

  // the DRAM side only takes what this stage offers
  assert property (@(posedge clk_i) disable iff (reset_i)
    ((dma_pkt_yumi_i & ~dma_pkt_v_o) == '0) && ((evict_yumi_i & ~evict_v_o) == '0));

endmodule

// File: dma_dram_model.sv
`timescale 1ns/1ps
`include "wh_dma_macros.svh"

module dma_dram_model (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  wh_dma_pkg::dma_pkt_s                        dma_pkt_i,
  input  logic [`NUM_SLOTS-1:0]                       dma_pkt_v_i,
  output logic [`NUM_SLOTS-1:0]                       dma_pkt_yumi_o,
  input  logic [`WH_FLIT_WIDTH-1:0]                   evict_data_i,
  input  logic [`NUM_SLOTS-1:0]                       evict_v_i,
  output logic [`NUM_SLOTS-1:0]                       evict_yumi_o,
  output logic [`NUM_SLOTS-1:0][`WH_FLIT_WIDTH-1:0]   fill_data_o,
  output logic [`NUM_SLOTS-1:0]                       fill_v_o,
  input  logic [`NUM_SLOTS-1:0]                       fill_ready_i
);

  import wh_dma_pkg::*;

  localparam int count_width_lp = $clog2(`BLOCK_WORDS);
  localparam int idx_width_lp   = $clog2(`DRAM_WORDS);

  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_WRITE,
    SLOT_READ
  } slot_state_e;

  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : slot_g
    dma_pkt_s                  q_data;
    logic                      q_ready;
    logic                      q_v;
    logic                      q_yumi;
    slot_state_e               state_r;
    logic [count_width_lp-1:0] count_r;
    logic [idx_width_lp-1:0]   base_r;
    logic [idx_width_lp-1:0]   idx;
    logic                      last;
    logic [`WH_FLIT_WIDTH-1:0] mem_r [`DRAM_WORDS];

    // one packet may wait here while the slot is busy
    wh_flit_fifo #(
      .payload_t(dma_pkt_s),
      .els_p    (1)
    ) u_pkt_q (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .v_i    (dma_pkt_v_i[i]),
      .data_i (dma_pkt_i),
      .ready_o(q_ready),
      .v_o    (q_v),
      .data_o (q_data),
      .yumi_i (q_yumi)
    );

    assign dma_pkt_yumi_o[i] = dma_pkt_v_i[i] & q_ready;
    assign q_yumi            = q_v & (state_r == SLOT_IDLE);

    // word address, wraps within the slot
    assign idx  = base_r + idx_width_lp'(count_r);
    assign last = (count_r == count_width_lp'(`BLOCK_WORDS - 1));

    assign evict_yumi_o[i] = evict_v_i[i] & (state_r == SLOT_WRITE);
    assign fill_v_o[i]     = (state_r == SLOT_READ);
    assign fill_data_o[i]  = mem_r[idx];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        state_r <= SLOT_IDLE;
        count_r <= '0;
        base_r  <= '0;
        for (int w = 0; w < `DRAM_WORDS; w++) begin
          mem_r[w] <= '0;
        end
      end else begin
        case (state_r)
          SLOT_IDLE: begin
            if (q_v) begin
              state_r <= q_data.write_not_read ? SLOT_WRITE : SLOT_READ;
              base_r  <= q_data.addr[2 +: idx_width_lp];
              count_r <= '0;
            end
          end
          SLOT_WRITE: begin
            if (evict_v_i[i]) begin
              mem_r[idx] <= evict_data_i;
              count_r    <= last ? '0 : count_r + 1'b1;
              state_r    <= last ? SLOT_IDLE : SLOT_WRITE;
            end
          end
          SLOT_READ: begin
            if (fill_ready_i[i]) begin
              count_r <= last ? '0 : count_r + 1'b1;
              state_r <= last ? SLOT_IDLE : SLOT_READ;
            end
          end
          default: begin
            state_r <= SLOT_IDLE;
          end
        endcase
      end
    end
  end

endmodule

// File: wh_dma_recv.sv
`timescale 1ns/1ps
`include "wh_dma_macros.svh"

module wh_dma_recv (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [`NUM_SLOTS-1:0][`WH_FLIT_WIDTH-1:0]   fill_data_i,
  input  logic [`NUM_SLOTS-1:0]                       fill_v_i,
  output logic [`NUM_SLOTS-1:0]                       fill_ready_o,
  output wh_dma_pkg::slot_id_t                        route_slot_o,
  input  wh_dma_pkg::wh_route_s                       route_i,
  output wh_dma_pkg::wh_link_s                        wh_link_o,
  input  logic                                        wh_ready_i
);

  import wh_dma_pkg::*;

  localparam int count_width_lp = $clog2(`BLOCK_WORDS);

  typedef enum logic [1:0] {
    RECV_RESET,
    RECV_READY,
    RECV_HEADER,
    RECV_DATA
  } recv_state_e;

  recv_state_e               state_r;
  recv_state_e               state_n;
  slot_id_t                  slot_r;
  slot_id_t                  last_r;
  slot_id_t                  grant_slot;
  logic                      grant_v;
  logic                      grant_take;
  wh_route_s                 route_r;
  wh_header_flit_s           header;
  logic [count_width_lp-1:0] count_r;
  logic                      last_word;

  // search starts one past the last grant
  always_comb begin
    grant_v    = 1'b0;
    grant_slot = last_r;
    for (int k = 1; k <= `NUM_SLOTS; k++) begin
      if (!grant_v && fill_v_i[slot_id_t'(last_r + k)]) begin
        grant_v    = 1'b1;
        grant_slot = slot_id_t'(last_r + k);
      end
    end
  end

  assign route_slot_o = grant_slot;
  assign grant_take   = (state_r == RECV_READY) & grant_v;
  assign last_word    = (count_r == count_width_lp'(`BLOCK_WORDS - 1));

  // reply goes back to the requester
  always_comb begin
    header           = '0;
    header.cid       = route_r.cid;
    header.len       = `WH_LEN_WIDTH'(`BLOCK_WORDS);
    header.dest_cord = route_r.src_cord;
  end

  always_comb begin
    state_n      = state_r;
    wh_link_o    = '0;
    fill_ready_o = '0;
    case (state_r)
      RECV_RESET: state_n = RECV_READY;
      RECV_READY: begin
        if (grant_v) begin
          state_n = RECV_HEADER;
        end
      end
      RECV_HEADER: begin
        wh_link_o.v    = 1'b1;
        wh_link_o.data = header;
        if (wh_ready_i) begin
          state_n = RECV_DATA;
        end
      end
      RECV_DATA: begin
        wh_link_o.v          = fill_v_i[slot_r];
        wh_link_o.data       = fill_data_i[slot_r];
        fill_ready_o[slot_r] = wh_ready_i;
        if (fill_v_i[slot_r] && wh_ready_i && last_word) begin
          state_n = RECV_READY;
        end
      end
      default: state_n = RECV_RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (grant_take) begin
      route_r <= route_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RECV_RESET;
      slot_r  <= '0;
      last_r  <= slot_id_t'(`NUM_SLOTS - 1);
      count_r <= '0;
    end else begin
      state_r <= state_n;
      if (grant_take) begin
        slot_r  <= grant_slot;
        last_r  <= grant_slot;
        count_r <= '0;
      end
      if (state_r == RECV_DATA && fill_v_i[slot_r] && wh_ready_i) begin
        count_r <= last_word ? '0 : count_r + 1'b1;
      end
    end
  end

  // an offered flit stays put until the link takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (wh_link_o.v && !wh_ready_i) |=> (wh_link_o.v && $stable(wh_link_o.data)));

endmodule

// File: wh_dma_bridge.sv
`timescale 1ns/1ps
`include "wh_dma_macros.svh"

module wh_dma_bridge (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  wh_dma_pkg::wh_link_s wh_link_i,
  output logic                 wh_ready_o,
  output wh_dma_pkg::wh_link_s wh_link_o,
  input  logic                 wh_ready_i
);

  import wh_dma_pkg::*;

  logic                                      fifo_v;
  logic                                      fifo_yumi;
  logic [`WH_FLIT_WIDTH-1:0]                 fifo_data;
  dma_pkt_s                                  dma_pkt;
  logic [`NUM_SLOTS-1:0]                     dma_pkt_v;
  logic [`NUM_SLOTS-1:0]                     dma_pkt_yumi;
  logic [`WH_FLIT_WIDTH-1:0]                 evict_data;
  logic [`NUM_SLOTS-1:0]                     evict_v;
  logic [`NUM_SLOTS-1:0]                     evict_yumi;
  logic [`NUM_SLOTS-1:0][`WH_FLIT_WIDTH-1:0] fill_data;
  logic [`NUM_SLOTS-1:0]                     fill_v;
  logic [`NUM_SLOTS-1:0]                     fill_ready;
  slot_id_t                                  route_slot;
  wh_route_s                                 route_data;

  // incoming request flits
  wh_flit_fifo #(
    .payload_t(logic [`WH_FLIT_WIDTH-1:0]),
    .els_p    (`IN_FIFO_ELS)
  ) u_in_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (wh_link_i.v),
    .data_i (wh_link_i.data),
    .ready_o(wh_ready_o),
    .v_o    (fifo_v),
    .data_o (fifo_data),
    .yumi_i (fifo_yumi)
  );

  wh_dma_send u_send (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fifo_v_i      (fifo_v),
    .fifo_data_i   (fifo_data),
    .fifo_yumi_o   (fifo_yumi),
    .dma_pkt_o     (dma_pkt),
    .dma_pkt_v_o   (dma_pkt_v),
    .dma_pkt_yumi_i(dma_pkt_yumi),
    .evict_data_o  (evict_data),
    .evict_v_o     (evict_v),
    .evict_yumi_i  (evict_yumi),
    .route_slot_i  (route_slot),
    .route_o       (route_data)
  );

  dma_dram_model u_dram (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dma_pkt_i     (dma_pkt),
    .dma_pkt_v_i   (dma_pkt_v),
    .dma_pkt_yumi_o(dma_pkt_yumi),
    .evict_data_i  (evict_data),
    .evict_v_i     (evict_v),
    .evict_yumi_o  (evict_yumi),
    .fill_data_o   (fill_data),
    .fill_v_o      (fill_v),
    .fill_ready_i  (fill_ready)
  );

  // response packets back onto the link
  wh_dma_recv u_recv (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_data_i (fill_data),
    .fill_v_i    (fill_v),
    .fill_ready_o(fill_ready),
    .route_slot_o(route_slot),
    .route_i     (route_data),
    .wh_link_o   (wh_link_o),
    .wh_ready_i  (wh_ready_i)
  );

endmodule

// File: tb_wh_dma_bridge.sv
`timescale 1ns/1ps
`include "wh_dma_macros.svh"

module tb_wh_dma_bridge;

  import wh_dma_pkg::*;

  localparam int rec_words_lp   = 7;
  localparam int max_records_lp = 64;
  // closing group of three reads per slot
  localparam int bp_records_lp  = 3 * `NUM_SLOTS;

  logic        clk;
  logic        reset;
  wh_link_s    link_in;
  logic        bridge_ready;
  wh_link_s    link_out;
  logic        out_ready;

  logic [31:0] golden_mem [rec_words_lp * max_records_lp];
  logic        golden_loaded = 1'b0;
  int          num_records;
  int          bp_first;
  int          pending_q [$];
  int          error_count;
  int          check_count;
  int          responses_seen;
  logic        in_packet;
  int          cur_rec;
  int          word_idx;

  wh_dma_bridge u_wh_dma_bridge (
    .clk_i     (clk),
    .reset_i   (reset),
    .wh_link_i (link_in),
    .wh_ready_o(bridge_ready),
    .wh_link_o (link_out),
    .wh_ready_i(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp_word,
                                 input logic [31:0] act_word);
    error_count++;
    $display("[FAIL] %s: expected %h, actual %h", what, exp_word, act_word);
  endtask

  function automatic string record_name(input int rec);
    wh_header_flit_s hdr;
    hdr = wh_header_flit_s'(golden_mem[rec * rec_words_lp]);
    return $sformatf("%s record %0d slot %0d", (rec >= bp_first) ? "backpressure" : "basic",
                     rec, hdr.src_cord % `NUM_SLOTS);
  endfunction

  // starts and ends 1 ns after a rising edge
  task automatic send_flit(input logic [31:0] flit);
    link_in.v    = 1'b1;
    link_in.data = flit;
    @(negedge clk);
    while (!bridge_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    link_in.v = 1'b0;
  endtask

  task automatic send_record(input int rec);
    int              base;
    wh_header_flit_s hdr;
    base = rec * rec_words_lp;
    hdr  = wh_header_flit_s'(golden_mem[base]);
    // reads expect a reply, writes carry a block of evict data
    if (golden_mem[base + 6] != '0) begin
      pending_q.push_back(rec);
    end
    send_flit(golden_mem[base]);
    send_flit(golden_mem[base + 1]);
    if (hdr.write_not_read) begin
      for (int w = 0; w < `BLOCK_WORDS; w++) begin
        send_flit(golden_mem[base + 2 + w]);
      end
    end
  endtask

  task automatic wait_drained();
    while (pending_q.size() != 0 || in_packet) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic hold_then_release();
    logic fell;
    fell = 1'b0;
    for (int c = 0; c < 200 && !fell; c++) begin
      @(negedge clk);
      if (!bridge_ready) begin
        fell = 1'b1;
      end
    end
    check_count++;
    if (!fell) begin
      error_count++;
      $display("wh_ready_o stayed high while the response link was stalled");
    end
    repeat (5) @(posedge clk);
    #1;
    out_ready = 1'b1;
  endtask

  // link transfers are sampled half a cycle before the edge that takes them
  initial begin : response_monitor
    int          match;
    logic [31:0] flit;
    logic [31:0] exp_word;
    forever begin
      @(negedge clk);
      if (reset) begin
        if (link_out.v) begin
          error_count++;
          $display("wh_link_o.v is high during reset");
        end
      end else if (link_out.v && out_ready) begin
        flit = link_out.data;
        if (!in_packet) begin
          // oldest pending read whose source matches this reply
          match = -1;
          for (int i = 0; i < pending_q.size(); i++) begin
            if (match < 0 &&
                golden_mem[pending_q[i] * rec_words_lp + 6][7:0] == flit[7:0]) begin
              match = i;
            end
          end
          in_packet = 1'b1;
          word_idx  = 0;
          cur_rec   = -1;
          check_count++;
          if (match < 0) begin
            error_count++;
            $display("response header %h matches no pending read", flit);
          end else begin
            cur_rec = pending_q[match];
            pending_q.delete(match);
            exp_word = golden_mem[cur_rec * rec_words_lp + 6];
            if (flit !== exp_word) begin
              report_mismatch({record_name(cur_rec), " header"}, exp_word, flit);
            end
          end
        end else begin
          if (cur_rec >= 0) begin
            exp_word = golden_mem[cur_rec * rec_words_lp + 2 + word_idx];
            check_count++;
            if (flit !== exp_word) begin
              report_mismatch($sformatf("%s data %0d", record_name(cur_rec), word_idx),
                              exp_word, flit);
            end
          end
          word_idx++;
          if (word_idx == `BLOCK_WORDS) begin
            in_packet = 1'b0;
            responses_seen++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (golden_loaded);
    repeat ((num_records + 1) * 200) @(posedge clk);
    $display("timeout after %0d cycles with responses still missing", (num_records + 1) * 200);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    int bp_expected;
    int all_expected;
    int bp_start;
    error_count    = 0;
    check_count    = 0;
    responses_seen = 0;
    in_packet      = 1'b0;
    cur_rec        = -1;
    word_idx       = 0;
    num_records    = 0;
    bp_expected    = 0;
    all_expected   = 0;
    reset          = 1'b1;
    link_in        = '0;
    out_ready      = 1'b1;

    // words past the last record stay all ones
    for (int i = 0; i < rec_words_lp * max_records_lp; i++) begin
      golden_mem[i] = '1;
    end
    $readmemh("wh_dma_golden.hex", golden_mem);
    while (num_records < max_records_lp &&
           golden_mem[num_records * rec_words_lp] != '1) begin
      num_records++;
    end
    bp_first = num_records - bp_records_lp;
    for (int r = 0; r < num_records; r++) begin
      if (golden_mem[r * rec_words_lp + 6] != '0) begin
        all_expected++;
        if (r >= bp_first) begin
          bp_expected++;
        end
      end
    end
    golden_loaded = 1'b1;

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_count += 2;
    if (bridge_ready !== 1'b1) begin
      report_mismatch("after reset wh_ready_o", 32'd1, 32'(bridge_ready));
    end
    if (link_out.v !== 1'b0) begin
      report_mismatch("after reset wh_link_o.v", 32'd0, 32'(link_out.v));
    end
    @(posedge clk);
    #1;

    if (num_records <= bp_records_lp) begin
      error_count++;
      $display("wh_dma_golden.hex holds only %0d records", num_records);
    end else begin
      for (int r = 0; r < bp_first; r++) begin
        send_record(r);
      end
      wait_drained();

      // stall the response link until the input side backs up
      bp_start  = responses_seen;
      out_ready = 1'b0;
      fork
        begin
          for (int r = bp_first; r < num_records; r++) begin
            send_record(r);
          end
        end
        hold_then_release();
      join
      wait_drained();
      check_count++;
      if (responses_seen - bp_start != bp_expected) begin
        error_count++;
        $display("[FAIL] backpressure response count: expected %0d, actual %0d",
                 bp_expected, responses_seen - bp_start);
      end

      // any flit from here on is a stray
      repeat (20) @(posedge clk);
      check_count++;
      if (responses_seen != all_expected) begin
        error_count++;
        $display("[FAIL] total response count: expected %0d, actual %0d",
                 all_expected, responses_seen);
      end
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: wh_dma_bridge.f
+incdir+.
wh_dma_pkg.sv
wh_flit_fifo.sv
wh_dma_send.sv
dma_dram_model.sv
wh_dma_recv.sv
wh_dma_bridge.sv
tb_wh_dma_bridge.sv

// File: Makefile
# Verilator flow for the DMA bridge testbench
TOP := tb_wh_dma_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f wh_dma_bridge.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f wh_dma_bridge.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "All tests passed!" sim.log || (echo "simulation failed, see sim.log"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: wh_dma_golden.hex
// header addr data0 data1 data2 data3 expected_response_header (zero for a write)
// a read record holds the expected fill words in its data columns
// basic sequence
00041100 00000100 00000000 00000000 00000000 00000000 00001410
0010C100 00000080 00000000 00000000 00000000 00000000 00000443
00441500 00000040 11110000 11110001 11110002 11110003 00000000
00041100 00000040 11110000 11110001 11110002 11110003 00001410
00486500 00000080 22220000 22220001 22220002 22220003 00000000
004CB500 00000080 33330000 33330001 33330002 33330003 00000000
0050C500 00000080 44440000 44440001 44440002 44440003 00000000
00086100 00000080 22220000 22220001 22220002 22220003 00002421
000CB100 00000080 33330000 33330001 33330002 33330003 00003432
0010C100 00000080 44440000 44440001 44440002 44440003 00000443
004CB500 000000FC A5A50000 A5A50001 A5A50002 A5A50003 00000000
000CB100 000000FC A5A50000 A5A50001 A5A50002 A5A50003 00003432
00486500 0ABC0140 5A5A0000 5A5A0001 5A5A0002 5A5A0003 00000000
00086100 00000040 5A5A0000 5A5A0001 5A5A0002 5A5A0003 00002421
0010C100 00000084 44440001 44440002 44440003 00000000 00000443
// last twelve records, three reads per slot, sent while the response link is stalled
00041100 00000040 11110000 11110001 11110002 11110003 00001410
00086100 00000080 22220000 22220001 22220002 22220003 00002421
000CB100 00000000 A5A50001 A5A50002 A5A50003 00000000 00003432
0010C100 00000080 44440000 44440001 44440002 44440003 00000443
00041100 00000100 00000000 00000000 00000000 00000000 00001410
00086100 00000040 5A5A0000 5A5A0001 5A5A0002 5A5A0003 00002421
000CB100 00000080 33330000 33330001 33330002 33330003 00003432
0010C100 00000084 44440001 44440002 44440003 00000000 00000443
00041100 00000044 11110001 11110002 11110003 00000000 00001410
00086100 0ABC0140 5A5A0000 5A5A0001 5A5A0002 5A5A0003 00002421
000CB100 000000FC A5A50000 A5A50001 A5A50002 A5A50003 00003432
0010C100 00000000 00000000 00000000 00000000 00000000 00000443
